//--- all.f
scope_pkg.sv
host_bus_bridge.sv
target_pin_ctrl.sv
la_capture.sv
sample_fifo.sv
status_leds.sv
scope_top.sv
tb_scope_top.sv

//--- Makefile
all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_scope_top -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_scope_top)"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- tb_scope_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scope_top import scope_pkg::*; ();

   logic      clk_usb_buf;
   logic      rst_n;
   reg_addr_t usb_addr;
   reg_data_t usb_wdata;
   logic      usb_rdn, usb_wrn, usb_cen;
   reg_data_t usb_rdata;
   logic      usb_data_oe;
   logic      sam_mosi, sam_spck, avr_rst, target_miso;
   logic      target_poweron, target_nrst, target_nrst_oe;
   logic      target_mosi, target_mosi_oe, target_sck, target_sck_oe;
   logic      sam_miso, sam_miso_oe;
   sample_t   la_probe;
   logic      pll_status;
   logic      led_adc, led_armed, led_cap;

   int        errors_value;
   int        errors_other;
   int        n, k, polls, bytes_read;
   reg_data_t ctrl, rd, count;
   sample_t   probe_val;
   logic      led_prev, toggled;

   scope_top #(
      .pFIFO_DEPTH (16),
      .pFLASH_BITS (4)
   ) i_dut (
      .clk_usb_buf      (clk_usb_buf),
      .rst_n_i          (rst_n),
      .usb_addr_i       (usb_addr),
      .usb_data_i       (usb_wdata),
      .usb_rdn_i        (usb_rdn),
      .usb_wrn_i        (usb_wrn),
      .usb_cen_i        (usb_cen),
      .usb_data_o       (usb_rdata),
      .usb_data_oe_o    (usb_data_oe),
      .sam_mosi_i       (sam_mosi),
      .sam_spck_i       (sam_spck),
      .avr_rst_i        (avr_rst),
      .target_miso_i    (target_miso),
      .target_poweron_o (target_poweron),
      .target_nrst_o    (target_nrst),
      .target_nrst_oe_o (target_nrst_oe),
      .target_mosi_o    (target_mosi),
      .target_mosi_oe_o (target_mosi_oe),
      .target_sck_o     (target_sck),
      .target_sck_oe_o  (target_sck_oe),
      .sam_miso_o       (sam_miso),
      .sam_miso_oe_o    (sam_miso_oe),
      .la_probe_i       (la_probe),
      .pll_status_i     (pll_status),
      .led_adc_o        (led_adc),
      .led_armed_o      (led_armed),
      .led_cap_o        (led_cap)
   );

   initial begin
      clk_usb_buf = 1'b0;
      forever #50 clk_usb_buf = ~clk_usb_buf;
   end

   task automatic check_eq(input string name, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp) else begin
         errors_value++;
         $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   // Strobe held 6 cycles with chip enable low until the pulse is out
   task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
      @(negedge clk_usb_buf);
      usb_addr  = addr;
      usb_wdata = data;
      usb_cen   = 1'b0;
      usb_wrn   = 1'b0;
      repeat (6) @(negedge clk_usb_buf);
      usb_wrn = 1'b1;
      repeat (3) @(negedge clk_usb_buf);
      usb_cen = 1'b1;
      @(negedge clk_usb_buf);
   endtask

   task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
      @(negedge clk_usb_buf);
      usb_addr = addr;
      usb_cen  = 1'b0;
      usb_rdn  = 1'b0;
      repeat (5) @(negedge clk_usb_buf);
      data = usb_rdata;
      assert (usb_data_oe === 1'b1) else begin
         errors_other++;
         $display("bus read at %0h: data output enable low while the read strobe is held", addr);
      end
      @(negedge clk_usb_buf);
      usb_rdn = 1'b1;
      repeat (3) @(negedge clk_usb_buf);   // Read-end pulse still needs chip enable
      usb_cen = 1'b1;
      @(negedge clk_usb_buf);
   endtask

   task automatic wait_capture_done(input string name);
      reg_data_t st;
      int        tries;
      st    = 8'h01;
      tries = 0;
      while (st[LA_ACTIVE_BIT] && tries < 200) begin
         bus_read(REG_LA_STATUS, st);
         tries++;
      end
      if (st[LA_ACTIVE_BIT]) begin
         errors_other++;
         $display("%s: capture still active after %0d status reads", name, tries);
      end
   endtask

   // Pin drive expected from the power, AVR programming and NRST bits
   task automatic check_pins(input reg_data_t c);
      logic power;
      logic avr;
      logic exp_nrst_oe;
      power       = !c[TGT_POWER_OFF_BIT];
      avr         = c[TGT_AVRPROG_BIT];
      exp_nrst_oe = power && (avr || c[TGT_NRST_OE_BIT]);
      check_eq("target poweron", power, target_poweron);
      check_eq("target nrst oe", exp_nrst_oe, target_nrst_oe);
      check_eq("target mosi oe", power && avr, target_mosi_oe);
      check_eq("target sck oe", power && avr, target_sck_oe);
      check_eq("sam miso oe", avr, sam_miso_oe);
      if (exp_nrst_oe)
         check_eq("target nrst", avr ? avr_rst : c[TGT_NRST_VAL_BIT], target_nrst);
      if (power && avr) begin
         check_eq("target mosi", sam_mosi, target_mosi);
         check_eq("target sck", sam_spck, target_sck);
      end
      if (avr)
         check_eq("sam miso", target_miso, sam_miso);
   endtask

   initial begin
      rst_n        = 1'b0;
      usb_addr     = '0;
      usb_wdata    = '0;
      usb_rdn      = 1'b1;
      usb_wrn      = 1'b1;
      usb_cen      = 1'b1;
      sam_mosi     = 1'b0;
      sam_spck     = 1'b0;
      avr_rst      = 1'b0;
      target_miso  = 1'b0;
      la_probe     = '0;
      pll_status   = 1'b1;
      errors_value = 0;
      errors_other = 0;
      n = $urandom(32'h8af59145);
      repeat (16) @(negedge clk_usb_buf);
      rst_n = 1'b1;
      @(negedge clk_usb_buf);

      // Reset state
      check_eq("reset poweron", 1'b0, target_poweron);
      check_eq("reset nrst oe", 1'b0, target_nrst_oe);
      check_eq("reset mosi oe", 1'b0, target_mosi_oe);
      check_eq("reset sck oe", 1'b0, target_sck_oe);
      check_eq("reset miso oe", 1'b0, sam_miso_oe);
      check_eq("reset data oe", 1'b0, usb_data_oe);
      check_eq("reset led adc", !pll_status, led_adc);
      bus_read(REG_LA_STATUS, rd);
      check_eq("reset la status", 8'h00, rd);
      bus_read(REG_FIFO_COUNT, rd);
      check_eq("reset fifo count", 8'h00, rd);

      // Target register over every combination of the four control bits
      for (n = 0; n < 16; n++) begin
         ctrl      = reg_data_t'($urandom);
         ctrl[3:0] = 4'(n);
         {sam_mosi, sam_spck, avr_rst, target_miso} = 4'($urandom);
         bus_write(REG_TARGET_CTRL, ctrl);
         bus_read(REG_TARGET_CTRL, rd);
         check_eq("target ctrl readback", ctrl, rd);
         check_pins(ctrl);
         {sam_mosi, sam_spck, avr_rst, target_miso} = ~{sam_mosi, sam_spck, avr_rst, target_miso};
         @(negedge clk_usb_buf);
         check_pins(ctrl);
      end
      bus_write(REG_TARGET_CTRL, 8'h01);

      // Capture without overrun
      probe_val = sample_t'($urandom);
      la_probe  = probe_val;
      bus_write(REG_LA_DIV, reg_data_t'($urandom % 4));
      bus_write(REG_LA_SAMPLES, 8'd10);
      bus_write(REG_LA_CTRL, 8'h01 << LA_ARM_BIT);
      check_eq("armed led", 1'b1, led_armed);
      check_eq("capture led", 1'b1, led_cap);
      wait_capture_done("short capture");
      bus_read(REG_FIFO_COUNT, rd);
      check_eq("short capture count", 8'd10, rd);
      for (n = 0; n < 10; n++) begin
         bus_read(REG_FIFO_DATA, rd);
         check_eq("short capture data", probe_val, rd);
      end
      bus_read(REG_FIFO_COUNT, rd);
      check_eq("short capture drained", 8'd0, rd);
      bus_read(REG_LA_STATUS, rd);
      check_eq("short capture overrun", 1'b0, rd[LA_OVERRUN_BIT]);

      // Capture with overrun and no reads
      probe_val = sample_t'($urandom);
      la_probe  = probe_val;
      bus_write(REG_LA_SAMPLES, 8'd24);
      bus_write(REG_LA_CTRL, 8'h01 << LA_ARM_BIT);
      wait_capture_done("overrun capture");
      bus_read(REG_FIFO_COUNT, rd);
      check_eq("overrun capture count", 8'd16, rd);
      bus_read(REG_LA_STATUS, rd);
      check_eq("overrun capture overrun", 1'b1, rd[LA_OVERRUN_BIT]);
      for (n = 0; n < 16; n++) begin
         bus_read(REG_FIFO_DATA, rd);
         check_eq("overrun capture data", probe_val, rd);
      end

      // Error LED flashes while overrun stays latched
      pll_status = 1'b0;
      led_prev   = led_adc;
      toggled    = 1'b0;
      for (n = 0; n < 64 && !toggled; n++) begin
         @(negedge clk_usb_buf);
         if (led_adc !== led_prev)
            toggled = 1'b1;
      end
      if (!toggled) begin
         errors_other++;
         $display("error led: led_adc did not toggle within 64 cycles of overrun");
      end
      bus_write(REG_LA_CTRL, 8'h01 << LA_CLEAR_BIT);
      // A full flash period with no flashing
      for (n = 0; n < 16; n++) begin
         check_eq("error led cleared", !pll_status, led_adc);
         @(negedge clk_usb_buf);
      end

      // Credit return while reading during the capture
      probe_val = sample_t'($urandom);
      la_probe  = probe_val;
      bus_write(REG_LA_DIV, 8'd11);
      bus_write(REG_LA_CTRL, 8'h01 << LA_ARM_BIT);
      bytes_read = 0;
      polls      = 0;
      while (led_cap && polls < 400) begin
         bus_read(REG_FIFO_COUNT, count);
         for (k = 0; k < count; k++) begin
            bus_read(REG_FIFO_DATA, rd);
            check_eq("credit return data", probe_val, rd);
            bytes_read++;
         end
         polls++;
      end
      if (led_cap) begin
         errors_other++;
         $display("credit return: capture still active after %0d polls", polls);
      end
      bus_read(REG_FIFO_COUNT, count);
      check_eq("credit return total", 8'd24, 8'(bytes_read + count));
      bus_read(REG_LA_STATUS, rd);
      check_eq("credit return overrun", 1'b0, rd[LA_OVERRUN_BIT]);

      $display("checks failed: %0d value mismatches, %0d other failures",
               errors_value, errors_other);
      if (errors_value == 0 && errors_other == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- scope_top.sv
`timescale 1ns/1ps
`default_nettype none

module scope_top import scope_pkg::*; #(
   parameter int pFIFO_DEPTH = 16,
   parameter int pFLASH_BITS = 4
) (
   input  wire            clk_usb_buf,
   input  wire            rst_n_i,
   input  wire reg_addr_t usb_addr_i,
   input  wire reg_data_t usb_data_i,
   input  wire            usb_rdn_i,
   input  wire            usb_wrn_i,
   input  wire            usb_cen_i,
   output reg_data_t      usb_data_o,
   output logic           usb_data_oe_o,
   input  wire            sam_mosi_i,
   input  wire            sam_spck_i,
   input  wire            avr_rst_i,
   input  wire            target_miso_i,
   output logic           target_poweron_o,
   output logic           target_nrst_o,
   output logic           target_nrst_oe_o,
   output logic           target_mosi_o,
   output logic           target_mosi_oe_o,
   output logic           target_sck_o,
   output logic           target_sck_oe_o,
   output logic           sam_miso_o,
   output logic           sam_miso_oe_o,
   input  wire sample_t   la_probe_i,
   input  wire            pll_status_i,
   output logic           led_adc_o,
   output logic           led_armed_o,
   output logic           led_cap_o
);

   reg_addr_t reg_addr;
   reg_data_t reg_wdata;
   logic      reg_write;
   logic      reg_read;
   reg_data_t read_data;
   reg_data_t rdata_tgt;
   reg_data_t rdata_la;
   reg_data_t rdata_fifo;
   logic      fifo_wr;
   sample_t   fifo_wdata;
   logic      fifo_flush;
   logic      credit_return;
   logic      la_active;
   logic      la_overrun;

   // Each block returns zero outside its own addresses
   always_ff @(posedge clk_usb_buf) begin
      read_data <= rdata_tgt | rdata_la | rdata_fifo;
   end

   host_bus_bridge i_bridge (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .read_data_i   (read_data),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_addr_o    (reg_addr),
      .reg_wdata_o   (reg_wdata),
      .reg_write_o   (reg_write),
      .reg_read_o    (reg_read)
   );

   target_pin_ctrl i_target (
      .clk_usb_buf      (clk_usb_buf),
      .rst_n_i          (rst_n_i),
      .reg_addr_i       (reg_addr),
      .reg_wdata_i      (reg_wdata),
      .reg_write_i      (reg_write),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .avr_rst_i        (avr_rst_i),
      .target_miso_i    (target_miso_i),
      .reg_rdata_o      (rdata_tgt),
      .target_poweron_o (target_poweron_o),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o)
   );

   la_capture #(
      .pFIFO_DEPTH (pFIFO_DEPTH)
   ) i_la (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .reg_addr_i      (reg_addr),
      .reg_wdata_i     (reg_wdata),
      .reg_write_i     (reg_write),
      .la_probe_i      (la_probe_i),
      .credit_return_i (credit_return),
      .reg_rdata_o     (rdata_la),
      .fifo_wr_o       (fifo_wr),
      .fifo_wdata_o    (fifo_wdata),
      .fifo_flush_o    (fifo_flush),
      .la_active_o     (la_active),
      .la_overrun_o    (la_overrun)
   );

   sample_fifo #(
      .pFIFO_DEPTH (pFIFO_DEPTH)
   ) i_fifo (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .reg_addr_i      (reg_addr),
      .reg_read_i      (reg_read),
      .fifo_wr_i       (fifo_wr),
      .fifo_wdata_i    (fifo_wdata),
      .fifo_flush_i    (fifo_flush),
      .reg_rdata_o     (rdata_fifo),
      .credit_return_o (credit_return)
   );

   status_leds #(
      .pFLASH_BITS (pFLASH_BITS)
   ) i_leds (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .error_i      (la_overrun),   // Overrun is the only error kept
      .la_active_i  (la_active),
      .pll_status_i (pll_status_i),
      .led_adc_o    (led_adc_o),
      .led_armed_o  (led_armed_o),
      .led_cap_o    (led_cap_o)
   );

endmodule

`default_nettype wire

//--- status_leds.sv
`timescale 1ns/1ps
`default_nettype none

module status_leds #(
   parameter int pFLASH_BITS = 4
) (
   input  wire  clk_usb_buf,
   input  wire  rst_n_i,
   input  wire  error_i,
   input  wire  la_active_i,
   input  wire  pll_status_i,
   output logic led_adc_o,
   output logic led_armed_o,
   output logic led_cap_o
);

   logic [pFLASH_BITS-1:0] flash_cnt_q;
   logic                   flash_pattern;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i)
         flash_cnt_q <= '0;
      else
         flash_cnt_q <= flash_cnt_q + 1'b1;
   end

   assign flash_pattern = flash_cnt_q[pFLASH_BITS-1];   // Half period 2^(N-1)

   // Fast flash on a latched error, PLL lock otherwise
   assign led_adc_o   = error_i ? flash_pattern : !pll_status_i;
   assign led_armed_o = la_active_i;
   assign led_cap_o   = la_active_i;

endmodule

`default_nettype wire

//--- sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import scope_pkg::*; #(
   parameter int pFIFO_DEPTH = 16
) (
   input  wire            clk_usb_buf,
   input  wire            rst_n_i,
   input  wire reg_addr_t reg_addr_i,
   input  wire            reg_read_i,
   input  wire            fifo_wr_i,
   input  wire sample_t   fifo_wdata_i,
   input  wire            fifo_flush_i,
   output reg_data_t      reg_rdata_o,
   output logic           credit_return_o
);

   localparam int AW = $clog2(pFIFO_DEPTH);
   localparam int CW = $clog2(pFIFO_DEPTH + 1);

   sample_t       mem_q [pFIFO_DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [CW-1:0] count_q;
   logic          empty;
   logic          pop;
   sample_t       head;

   // Wraps at any depth, not only powers of two
   function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
      if (ptr == AW'(pFIFO_DEPTH - 1))
         ptr_next = '0;
      else
         ptr_next = ptr + 1'b1;
   endfunction

   assign empty = (count_q == '0);
   assign pop   = reg_read_i && (reg_addr_i == REG_FIFO_DATA) && !empty && !fifo_flush_i;
   assign head  = empty ? '0 : mem_q[rd_ptr_q];

   assign credit_return_o = pop;   // One credit back per entry freed

   always_ff @(posedge clk_usb_buf) begin
      if (fifo_wr_i)
         mem_q[wr_ptr_q] <= fifo_wdata_i;
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else if (fifo_flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (fifo_wr_i)
            wr_ptr_q <= ptr_next(wr_ptr_q);
         if (pop)
            rd_ptr_q <= ptr_next(rd_ptr_q);
         count_q <= count_q + CW'(fifo_wr_i) - CW'(pop);
      end
   end

   always_comb begin
      case (reg_addr_i)
         REG_FIFO_COUNT: reg_rdata_o = reg_data_t'(count_q);
         REG_FIFO_DATA:  reg_rdata_o = head;
         default:        reg_rdata_o = '0;
      endcase
   end

   // The writer's credit count must keep it off a full FIFO
   a_no_write_full: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      fifo_wr_i |-> (count_q != CW'(pFIFO_DEPTH)));

endmodule

`default_nettype wire

//--- la_capture.sv
`timescale 1ns/1ps
`default_nettype none

module la_capture import scope_pkg::*; #(
   parameter int pFIFO_DEPTH = 16
) (
   input  wire            clk_usb_buf,
   input  wire            rst_n_i,
   input  wire reg_addr_t reg_addr_i,
   input  wire reg_data_t reg_wdata_i,
   input  wire            reg_write_i,
   input  wire sample_t   la_probe_i,
   input  wire            credit_return_i,
   output reg_data_t      reg_rdata_o,
   output logic           fifo_wr_o,
   output sample_t        fifo_wdata_o,
   output logic           fifo_flush_o,
   output logic           la_active_o,
   output logic           la_overrun_o
);

   localparam int CW = $clog2(pFIFO_DEPTH + 1);

   typedef enum logic {
      ST_IDLE,
      ST_CAPTURE
   } la_state_e;

   la_state_e     state_q;
   reg_data_t     samples_q;
   reg_data_t     div_q;
   reg_data_t     timer_q;        // Cycles left to the next slot
   reg_data_t     slots_left_q;
   logic [CW-1:0] credit_q;       // Free FIFO entries not yet claimed
   logic          overrun_q;

   logic ctrl_wr;
   logic arm_req;
   logic clear_req;
   logic slot;
   logic take;

   assign ctrl_wr   = reg_write_i && (reg_addr_i == REG_LA_CTRL);
   assign arm_req   = ctrl_wr && reg_wdata_i[LA_ARM_BIT];
   assign clear_req = ctrl_wr && reg_wdata_i[LA_CLEAR_BIT];
   assign slot      = (state_q == ST_CAPTURE) && (timer_q == '0) && !arm_req;
   assign take      = slot && (credit_q != '0);

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         samples_q <= '0;
         div_q     <= '0;
      end else if (reg_write_i) begin
         if (reg_addr_i == REG_LA_SAMPLES)
            samples_q <= reg_wdata_i;
         if (reg_addr_i == REG_LA_DIV)
            div_q <= reg_wdata_i;
      end
   end

   // Zero samples runs a full 256 slots
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q      <= ST_IDLE;
         timer_q      <= '0;
         slots_left_q <= '0;
      end else if (arm_req) begin
         state_q      <= ST_CAPTURE;   // Re-arm restarts a running capture
         timer_q      <= div_q;
         slots_left_q <= samples_q;
      end else if (state_q == ST_CAPTURE) begin
         if (slot) begin
            timer_q      <= div_q;
            slots_left_q <= slots_left_q - 1'b1;
            if (slots_left_q == 8'd1)
               state_q <= ST_IDLE;
         end else begin
            timer_q <= timer_q - 1'b1;
         end
      end
   end

   // Credits refill together with the flush request
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         credit_q  <= CW'(pFIFO_DEPTH);
         overrun_q <= 1'b0;
      end else begin
         if (arm_req)
            credit_q <= CW'(pFIFO_DEPTH);
         else
            credit_q <= credit_q - CW'(take) + CW'(credit_return_i);
         if (clear_req)
            overrun_q <= 1'b0;
         else if (slot && (credit_q == '0))
            overrun_q <= 1'b1;   // Sample dropped, slot still counted
      end
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fifo_wr_o    <= 1'b0;
         fifo_flush_o <= 1'b0;
      end else begin
         fifo_wr_o    <= take;
         fifo_flush_o <= arm_req;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (take)
         fifo_wdata_o <= la_probe_i;
   end

   assign la_active_o  = (state_q == ST_CAPTURE);
   assign la_overrun_o = overrun_q;

   always_comb begin
      reg_rdata_o = '0;
      case (reg_addr_i)
         REG_LA_CTRL:    reg_rdata_o[LA_ARM_BIT] = la_active_o;
         REG_LA_SAMPLES: reg_rdata_o = samples_q;
         REG_LA_DIV:     reg_rdata_o = div_q;
         REG_LA_STATUS: begin
            reg_rdata_o[LA_ACTIVE_BIT]  = la_active_o;
            reg_rdata_o[LA_OVERRUN_BIT] = overrun_q;
         end
         default: ;
      endcase
   end

   // Credits returned by the FIFO never outnumber the ones spent
   a_credit_bound: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      credit_q <= CW'(pFIFO_DEPTH));

endmodule

`default_nettype wire

//--- target_pin_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module target_pin_ctrl import scope_pkg::*; (
   input  wire            clk_usb_buf,
   input  wire            rst_n_i,
   input  wire reg_addr_t reg_addr_i,
   input  wire reg_data_t reg_wdata_i,
   input  wire            reg_write_i,
   input  wire            sam_mosi_i,
   input  wire            sam_spck_i,
   input  wire            avr_rst_i,
   input  wire            target_miso_i,
   output reg_data_t      reg_rdata_o,
   output logic           target_poweron_o,
   output logic           target_nrst_o,
   output logic           target_nrst_oe_o,
   output logic           target_mosi_o,
   output logic           target_mosi_oe_o,
   output logic           target_sck_o,
   output logic           target_sck_oe_o,
   output logic           sam_miso_o,
   output logic           sam_miso_oe_o
);

   reg_data_t ctrl_q;
   logic      power_on;
   logic      avrprog;
   logic      nrst_oe;
   logic      nrst_val;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         // Target starts unpowered
         ctrl_q <= reg_data_t'(1) << TGT_POWER_OFF_BIT;
      end else if (reg_write_i && (reg_addr_i == REG_TARGET_CTRL)) begin
         ctrl_q <= reg_wdata_i;
      end
   end

   assign reg_rdata_o = (reg_addr_i == REG_TARGET_CTRL) ? ctrl_q : '0;

   assign power_on = !ctrl_q[TGT_POWER_OFF_BIT];
   assign avrprog  = ctrl_q[TGT_AVRPROG_BIT];
   assign nrst_oe  = ctrl_q[TGT_NRST_OE_BIT];
   assign nrst_val = ctrl_q[TGT_NRST_VAL_BIT];

   assign target_poweron_o = power_on;

   // Unpowered target sees every pin floating
   assign target_nrst_oe_o = power_on && (avrprog || nrst_oe);
   assign target_nrst_o    = avrprog ? avr_rst_i : nrst_val;

   // SPI programming pass-through from the SAM
   assign target_mosi_oe_o = power_on && avrprog;
   assign target_mosi_o    = sam_mosi_i;
   assign target_sck_oe_o  = power_on && avrprog;
   assign target_sck_o     = sam_spck_i;

   // MISO back to the SAM ignores power
   assign sam_miso_oe_o = avrprog;
   assign sam_miso_o    = target_miso_i;

endmodule

`default_nettype wire

//--- host_bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module host_bus_bridge import scope_pkg::*; (
   input  wire            clk_usb_buf,
   input  wire            rst_n_i,
   input  wire reg_addr_t usb_addr_i,
   input  wire reg_data_t usb_data_i,
   input  wire            usb_rdn_i,
   input  wire            usb_wrn_i,
   input  wire            usb_cen_i,
   input  wire reg_data_t read_data_i,
   output reg_data_t      usb_data_o,
   output logic           usb_data_oe_o,
   output reg_addr_t      reg_addr_o,
   output reg_data_t      reg_wdata_o,
   output logic           reg_write_o,
   output logic           reg_read_o
);

   // Strobe synchronizers, third stage is the edge-detect history
   logic rdn_s1, rdn_s2, rdn_s3;
   logic wrn_s1, wrn_s2, wrn_s3;
   logic cen_s1, cen_s2, cen_s3;

   // Pins sampled on the same edge as the first sync stage
   reg_addr_t addr_s1;
   reg_data_t data_s1;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         {rdn_s1, rdn_s2, rdn_s3} <= 3'b111;   // Strobes idle high
         {wrn_s1, wrn_s2, wrn_s3} <= 3'b111;
         {cen_s1, cen_s2, cen_s3} <= 3'b111;
      end else begin
         {rdn_s3, rdn_s2, rdn_s1} <= {rdn_s2, rdn_s1, usb_rdn_i};
         {wrn_s3, wrn_s2, wrn_s1} <= {wrn_s2, wrn_s1, usb_wrn_i};
         {cen_s3, cen_s2, cen_s1} <= {cen_s2, cen_s1, usb_cen_i};
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      addr_s1 <= usb_addr_i;
      data_s1 <= usb_data_i;
      if (!cen_s1 && !wrn_s1)
         reg_wdata_o <= data_s1;   // Last value held under the write strobe
   end

   // Pulses on the rising edge of each synchronized strobe
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         reg_write_o <= 1'b0;
         reg_read_o  <= 1'b0;
         reg_addr_o  <= '0;
      end else begin
         reg_write_o <= wrn_s2 && !wrn_s3 && !cen_s3;
         reg_read_o  <= rdn_s2 && !rdn_s3 && !cen_s3;
         if (!cen_s1 && (!wrn_s1 || !rdn_s1))
            reg_addr_o <= addr_s1;
      end
   end

   // Drive the bus while a read is in progress
   assign usb_data_oe_o = !rdn_s2 && !cen_s2;
   assign usb_data_o    = read_data_i;

   // The host never overlaps read and write strobes
   a_no_wr_rd_overlap: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !(reg_write_o && reg_read_o));

endmodule

`default_nettype wire

//--- scope_pkg.sv
`default_nettype none

package scope_pkg;

   // Host register bus
   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;   // Also carries the FIFO fill level

   // One probe sample from the logic analyzer
   typedef logic [7:0] sample_t;

   // Target pin control
   localparam reg_addr_t REG_TARGET_CTRL = 8'h10;

   // Logic-analyzer capture
   localparam reg_addr_t REG_LA_CTRL    = 8'h20;
   localparam reg_addr_t REG_LA_SAMPLES = 8'h21;   // Slots per capture
   localparam reg_addr_t REG_LA_DIV     = 8'h22;   // Slot period minus one
   localparam reg_addr_t REG_LA_STATUS  = 8'h23;

   // Sample FIFO read-back
   localparam reg_addr_t REG_FIFO_COUNT = 8'h30;
   localparam reg_addr_t REG_FIFO_DATA  = 8'h31;   // Pops at the end of the read

   // REG_TARGET_CTRL bits
   localparam int TGT_POWER_OFF_BIT = 0;
   localparam int TGT_AVRPROG_BIT   = 1;
   localparam int TGT_NRST_OE_BIT   = 2;
   localparam int TGT_NRST_VAL_BIT  = 3;

   // REG_LA_CTRL bits, both act as commands
   localparam int LA_ARM_BIT   = 0;
   localparam int LA_CLEAR_BIT = 1;

   // REG_LA_STATUS bits
   localparam int LA_ACTIVE_BIT  = 0;
   localparam int LA_OVERRUN_BIT = 1;

endpackage

`default_nettype wire
